//--- src/aes_config.svh
`ifndef AES_CONFIG_SVH
`define AES_CONFIG_SVH

// ==========================================================================
// AES-128 core sizes
// ==========================================================================

// Data block and cipher key widths in bits
`define AES_BLOCK_BITS 128
`define AES_KEY_BITS 128

// Full rounds after the initial AddRoundKey
`define AES_NUM_ROUNDS 10

// Low byte of x^8 + x^4 + x^3 + x + 1
`define AES_REDUCE_POLY 8'h1b

`endif

//--- src/aes_pkg.sv
`include "aes_config.svh"

package aes_pkg;

    // ======================================================================
    // Types
    // ======================================================================

    typedef logic [`AES_BLOCK_BITS-1:0] block_t;
    typedef logic [`AES_KEY_BITS-1:0]   key_t;
    typedef logic [31:0]                word_t;
    typedef logic [7:0]                 byte_t;
    typedef logic [3:0]                 round_t;

    typedef enum logic {
        st_idle,
        st_running
    } ctrl_state_t;

    // ======================================================================
    // Forward S-box
    // ======================================================================

    // Indexed by the input byte, 16 entries per row pair
    localparam byte_t sbox_table [256] = '{
        8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
        8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
        8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
        8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
        8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
        8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
        8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
        8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
        8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
        8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
        8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
        8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
        8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
        8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
        8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
        8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
        8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
        8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
        8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
        8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
        8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
        8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
        8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
        8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
        8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
        8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
        8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
        8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
        8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
        8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
        8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
        8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
    };

    function automatic byte_t sbox_lookup(byte_t b);
        return sbox_table[b];
    endfunction

    // ======================================================================
    // GF(2^8) arithmetic
    // ======================================================================

    // Multiply by x, reducing when the top bit falls out
    function automatic byte_t gf_double(byte_t b);
        byte_t shifted;
        shifted = {b[6:0], 1'b0};
        if (b[7]) begin
            shifted = shifted ^ `AES_REDUCE_POLY;
        end
        return shifted;
    endfunction

endpackage

//--- src/aes_round_ctrl.sv
`include "aes_config.svh"

module aes_round_ctrl
    import aes_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    output logic load,
    output logic step,
    output logic final_round,
    output logic busy,
    output logic done
);

    ctrl_state_t state_q;
    round_t      round_cnt;

    assign busy = (state_q == st_running);
    assign load = start && !busy;

    // Counter runs 1..N with a step each, then one tail cycle before done
    assign step        = busy && (round_cnt <= round_t'(`AES_NUM_ROUNDS));
    assign final_round = busy && (round_cnt == round_t'(`AES_NUM_ROUNDS));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= st_idle;
            round_cnt <= '0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state_q)
                st_idle: begin
                    if (load) begin
                        state_q   <= st_running;
                        round_cnt <= round_t'(1);
                    end
                end
                st_running: begin
                    round_cnt <= round_cnt + round_t'(1);
                    if (round_cnt == round_t'(`AES_NUM_ROUNDS + 1)) begin
                        state_q <= st_idle;
                        done    <= 1'b1;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

endmodule

//--- src/aes_key_schedule.sv
module aes_key_schedule
    import aes_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  key_t key,
    input  logic load,
    input  logic step,
    output key_t round_key
);

    key_t  cur_key;
    byte_t rcon;
    word_t prev_w [4];
    word_t next_w [4];
    word_t rot_word;
    word_t sub_word;

    // Next round key straight from the current one
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            prev_w[i] = cur_key[127 - 32*i -: 32];
        end
        rot_word = {prev_w[3][23:0], prev_w[3][31:24]};
        sub_word = {sbox_lookup(rot_word[31:24]), sbox_lookup(rot_word[23:16]),
                    sbox_lookup(rot_word[15:8]), sbox_lookup(rot_word[7:0])};
        next_w[0] = prev_w[0] ^ sub_word ^ {rcon, 24'h000000};
        for (int i = 1; i < 4; i++) begin
            next_w[i] = prev_w[i] ^ next_w[i-1];
        end
    end

    assign round_key = {next_w[0], next_w[1], next_w[2], next_w[3]};

    always_ff @(posedge clk) begin
        if (!rst_n || load) begin
            rcon <= 8'h01;
        end else if (step) begin
            rcon <= gf_double(rcon);
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            cur_key <= key;
        end else if (step) begin
            cur_key <= round_key;
        end
    end

endmodule

//--- src/aes_round.sv
module aes_round
    import aes_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  block_t plaintext,
    input  key_t   key,
    input  logic   load,
    input  logic   step,
    input  logic   final_round,
    input  key_t   round_key,
    output block_t state
);

    block_t shift_rows;
    block_t mixed;
    block_t round_out;

    // ======================================================================
    // SubBytes and ShiftRows
    // ======================================================================

    // Byte i is row i%4 of column i/4; row r rotates left by r columns
    for (genvar i = 0; i < 16; i++) begin : g_sub_shift
        localparam int row = i % 4;
        localparam int src = row + 4 * (((i / 4) + row) % 4);

        assign shift_rows[127 - 8*i -: 8] = sbox_lookup(state[127 - 8*src -: 8]);
    end

    // ======================================================================
    // MixColumns
    // ======================================================================

    for (genvar c = 0; c < 4; c++) begin : g_mix
        byte_t a [4];
        byte_t d [4];
        word_t mixed_col;

        always_comb begin
            for (int r = 0; r < 4; r++) begin
                a[r] = shift_rows[127 - 32*c - 8*r -: 8];
                d[r] = gf_double(a[r]);
            end
            // 2*a[r] ^ 3*a[r+1] ^ a[r+2] ^ a[r+3]
            for (int r = 0; r < 4; r++) begin
                mixed_col[31 - 8*r -: 8] = d[r] ^ d[(r+1)%4] ^ a[(r+1)%4]
                                         ^ a[(r+2)%4] ^ a[(r+3)%4];
            end
        end

        assign mixed[127 - 32*c -: 32] = mixed_col;
    end

    // Last round has no MixColumns
    assign round_out = (final_round ? shift_rows : mixed) ^ round_key;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= '0;
        end else if (load) begin
            state <= plaintext ^ key;
        end else if (step) begin
            state <= round_out;
        end
    end

endmodule

//--- src/aes_encrypt_top.sv
module aes_encrypt_top
    import aes_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   start,
    input  block_t plaintext,
    input  key_t   key,
    output logic   busy,
    output logic   done,
    output block_t ciphertext
);

    logic load;
    logic step;
    logic final_round;
    key_t round_key;

    aes_round_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .load        (load),
        .step        (step),
        .final_round (final_round),
        .busy        (busy),
        .done        (done)
    );

    aes_key_schedule u_keys (
        .clk       (clk),
        .rst_n     (rst_n),
        .key       (key),
        .load      (load),
        .step      (step),
        .round_key (round_key)
    );

    aes_round u_round (
        .clk         (clk),
        .rst_n       (rst_n),
        .plaintext   (plaintext),
        .key         (key),
        .load        (load),
        .step        (step),
        .final_round (final_round),
        .round_key   (round_key),
        .state       (ciphertext)
    );

endmodule

//--- tests/aes_asserts.sv
module aes_asserts
    import aes_pkg::*;
(
    input logic   clk,
    input logic   rst_n,
    input logic   start,
    input logic   busy,
    input logic   done,
    input block_t ciphertext
);

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else $error("done stayed high for more than one cycle");

    a_done_not_busy: assert property (@(posedge clk) disable iff (!rst_n) !(done && busy))
        else $error("done and busy were high together");

    // Idle with no start means the last result must hold
    a_result_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (!busy && !start) |=> $stable(ciphertext))
        else $error("ciphertext changed before the next accepted start");

endmodule

bind aes_encrypt_top aes_asserts u_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .busy       (busy),
    .done       (done),
    .ciphertext (ciphertext)
);

//--- tests/aes_tb.sv
module aes_tb
    import aes_pkg::*;
();

    localparam int done_latency = 11;
    localparam int done_timeout = 40;
    localparam int num_random   = 200;

    logic   clk;
    logic   rst_n;
    logic   start;
    block_t plaintext;
    key_t   key;
    logic   busy;
    logic   done;
    block_t ciphertext;

    logic [31:0] rng_state;
    byte_t       ref_sbox [256];

    aes_encrypt_top u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .plaintext  (plaintext),
        .key        (key),
        .busy       (busy),
        .done       (done),
        .ciphertext (ciphertext)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ======================================================================
    // Random numbers and reference model
    // ======================================================================

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [127:0] rand_block();
        return {next_rand(), next_rand(), next_rand(), next_rand()};
    endfunction

    // Shift-and-add multiply in GF(2^8)
    function automatic byte_t gf_mul(byte_t a, byte_t b);
        byte_t p;
        byte_t x;
        p = 8'h00;
        x = a;
        for (int i = 0; i < 8; i++) begin
            p = p ^ (b[i] ? x : 8'h00);
            x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
        end
        return p;
    endfunction

    // Field inverse by search, then the affine map
    task automatic build_sbox();
        byte_t b;
        for (int x = 0; x < 256; x++) begin
            b = 8'h00;
            for (int y = 1; y < 256; y++) begin
                if (gf_mul(byte_t'(x), byte_t'(y)) == 8'h01) begin
                    b = byte_t'(y);
                end
            end
            ref_sbox[x] = b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]}
                        ^ {b[4:0], b[7:5]} ^ {b[3:0], b[7:4]} ^ 8'h63;
        end
    endtask

    function automatic block_t ref_encrypt(block_t pt, key_t k);
        byte_t  s [16];
        byte_t  t [16];
        word_t  w [44];
        word_t  tmp;
        byte_t  rcon;
        block_t out;
        rcon = 8'h01;
        for (int i = 0; i < 4; i++) begin
            w[i] = k[127 - 32*i -: 32];
        end
        for (int i = 4; i < 44; i++) begin
            tmp = w[i-1];
            if (i % 4 == 0) begin
                tmp = {tmp[23:0], tmp[31:24]};
                tmp = {ref_sbox[tmp[31:24]], ref_sbox[tmp[23:16]],
                       ref_sbox[tmp[15:8]], ref_sbox[tmp[7:0]]} ^ {rcon, 24'h000000};
                rcon = gf_mul(rcon, 8'h02);
            end
            w[i] = w[i-4] ^ tmp;
        end
        for (int i = 0; i < 16; i++) begin
            s[i] = pt[127 - 8*i -: 8] ^ k[127 - 8*i -: 8];
        end
        for (int rnd = 1; rnd <= 10; rnd++) begin
            // Byte r of column c comes from column c+r
            for (int i = 0; i < 16; i++) begin
                t[i] = ref_sbox[s[4*(((i/4) + (i%4)) % 4) + i%4]];
            end
            for (int c = 0; c < 4; c++) begin
                for (int r = 0; r < 4; r++) begin
                    s[4*c+r] = (rnd == 10) ? t[4*c+r] :
                        gf_mul(t[4*c+r], 8'h02) ^ gf_mul(t[4*c+(r+1)%4], 8'h03)
                        ^ t[4*c+(r+2)%4] ^ t[4*c+(r+3)%4];
                end
            end
            for (int i = 0; i < 16; i++) begin
                s[i] = s[i] ^ w[4*rnd + i/4][31 - 8*(i%4) -: 8];
            end
        end
        for (int i = 0; i < 16; i++) begin
            out[127 - 8*i -: 8] = s[i];
        end
        return out;
    endfunction

    // ======================================================================
    // Checks and bus tasks
    // ======================================================================

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED: %s expected %0h actual %0h", name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // Called on a falling edge, returns on the one after the accepting edge
    task automatic start_op(input block_t pt, input key_t k);
        plaintext = pt;
        key       = k;
        start     = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_for_done(input string name, input int edges_before, output int edges);
        edges = edges_before;
        while (!done) begin
            if (edges >= done_timeout) begin
                $display("ERROR: %s: done never arrived within %0d cycles", name, edges);
                $display("Simulation FAILED");
                $fatal(1, "timeout in %s", name);
            end
            @(negedge clk);
            edges++;
        end
    endtask

    // ======================================================================
    // Tests
    // ======================================================================

    initial begin
        block_t pt;
        key_t   k;
        block_t expected;
        int     edges;
        int     gap;
        rst_n     = 1'b0;
        start     = 1'b0;
        plaintext = '0;
        key       = '0;
        rng_state = 32'd19427;
        build_sbox();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        check_value("reset_busy", 0, busy);
        check_value("reset_done", 0, done);
        check_value("reset_state", 0, ciphertext);
        pt = 128'h00112233445566778899aabbccddeeff;
        k  = 128'h000102030405060708090a0b0c0d0e0f;
        check_value("fips197_model", 128'h69c4e0d86a7b0430d8cdb78070b4c55a, ref_encrypt(pt, k));
        start_op(pt, k);
        wait_for_done("fips197", 0, edges);
        check_value("fips197", 128'h69c4e0d86a7b0430d8cdb78070b4c55a, ciphertext);
        @(negedge clk);
        check_value("fips197_done_width", 0, done);

        for (int n = 0; n < num_random; n++) begin
            pt = rand_block();
            k  = rand_block();
            start_op(pt, k);
            check_value("random_busy", 1, busy);
            wait_for_done("random", 0, edges);
            check_value("random_latency", done_latency, edges);
            check_value("random", ref_encrypt(pt, k), ciphertext);
            @(negedge clk);
        end

        // Second start lands mid-operation and must be dropped
        pt = rand_block();
        k  = rand_block();
        start_op(pt, k);
        gap = 1 + int'(next_rand() % 8);
        repeat (gap) @(negedge clk);
        start_op(rand_block(), rand_block());
        check_value("ignored_start_busy", 1, busy);
        wait_for_done("ignored_start", gap + 1, edges);
        check_value("ignored_start_latency", done_latency, edges);
        check_value("ignored_start", ref_encrypt(pt, k), ciphertext);

        for (int n = 0; n < 5; n++) begin
            @(negedge clk);
            pt = rand_block();
            k  = rand_block();
            expected = ref_encrypt(pt, k);
            start_op(pt, k);
            wait_for_done("idle_hold", 0, edges);
            check_value("idle_hold_result", expected, ciphertext);
            gap = 1 + int'(next_rand() % 20);
            repeat (gap) begin
                plaintext = rand_block();
                key       = rand_block();
                @(negedge clk);
                check_value("idle_hold", expected, ciphertext);
                check_value("idle_hold_busy", 0, busy);
            end
        end

        pt = rand_block();
        k  = rand_block();
        start_op(pt, k);
        wait_for_done("back_to_back_first", 0, edges);
        for (int n = 0; n < 10; n++) begin
            check_value("back_to_back", ref_encrypt(pt, k), ciphertext);
            pt = rand_block();
            k  = rand_block();
            start_op(pt, k);
            check_value("back_to_back_busy", 1, busy);
            wait_for_done("back_to_back", 0, edges);
            check_value("back_to_back_latency", done_latency, edges);
        end
        check_value("back_to_back_last", ref_encrypt(pt, k), ciphertext);

        @(negedge clk);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- build.f
+incdir+src
src/aes_pkg.sv
src/aes_round_ctrl.sv
src/aes_key_schedule.sv
src/aes_round.sv
src/aes_encrypt_top.sv
tests/aes_asserts.sv
tests/aes_tb.sv
